// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the controller testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_core_controller -Mdir obj_dir -f tb.f

out=$(./obj_dir/Vtb_core_controller)
echo "$out"

# fails the script unless the pass line is present
echo "$out" | grep -q "^TEST PASS$"

// File: src/core_controller.sv
//////////////////////////////
// core controller top level
// exception detect, irq arbiter and FSM
//////////////////////////////
module core_controller import core_ctrl_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  // ID stage
  input  instr_info_t     instr_i,
  input  dec_flags_t      dec_i,
  input  logic            stall_id_i,
  // LSU
  input  logic            load_err_i,
  input  logic            store_err_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  // control flow from EX
  input  logic            branch_set_i,
  input  logic            jump_set_i,
  // interrupts and csr state
  input  logic            irq_pending_i,
  input  irqs_t           irqs_i,
  input  logic            irq_nm_i,
  input  logic            mstatus_mie_i,
  input  logic            mstatus_tw_i,
  input  priv_lvl_e       priv_i,
  // to IF and CSRs
  output pc_ctrl_t        pc_o,
  output csr_ctrl_t       csr_o,
  output logic            instr_req_o,
  output logic            id_in_ready_o,
  output logic            instr_valid_clear_o,
  output logic            flush_id_o,
  output logic            ctrl_busy_o,
  output logic            controller_run_o,
  output logic            nmi_mode_o
);

  exc_req_t    exc_req;
  irq_req_t    irq_req;
  ctrl_state_e state;

  exc_detect u_exc_detect (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_i         (instr_i),
    .dec_i           (dec_i),
    .priv_i          (priv_i),
    .mstatus_tw_i    (mstatus_tw_i),
    .load_err_i      (load_err_i),
    .store_err_i     (store_err_i),
    .lsu_addr_last_i (lsu_addr_last_i),
    .state_i         (state),
    .exc_o           (exc_req)
  );

  // nmi mode from the FSM blocks nesting
  irq_arbiter u_irq_arbiter (
    .irqs_i        (irqs_i),
    .irq_nm_i      (irq_nm_i),
    .irq_pending_i (irq_pending_i),
    .mstatus_mie_i (mstatus_mie_i),
    .nmi_mode_i    (nmi_mode_o),
    .irq_o         (irq_req)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .stall_id_i          (stall_id_i),
    .instr_valid_i       (instr_i.valid),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .irq_nm_i            (irq_nm_i),
    .irq_pending_i       (irq_pending_i),
    .exc_i               (exc_req),
    .irq_i               (irq_req),
    .pc_o                (pc_o),
    .csr_o               (csr_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .nmi_mode_o          (nmi_mode_o),
    .state_o             (state)
  );

endmodule

// File: src/core_ctrl_pkg.sv
//////////////////////////////
// constants, enums and packed structs
// shared by the controller blocks and the testbench
//////////////////////////////
package core_ctrl_pkg;

  // sizes fixed by the isa encoding
  localparam int unsigned XLEN          = 32;
  localparam int unsigned NUM_FAST_IRQS = 16;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // fetch address select towards the IF stage
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3
  } pc_sel_e;

  // vector select, only looked at with PC_EXC
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // msb marks an interrupt
  // fast lines are {3'b101, id}, so fast 0 lands on cause 16
  typedef enum logic [6:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = {1'b0, 6'd0},
    EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 6'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 6'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 6'd3},
    EXC_CAUSE_LOAD_ACCESS_FAULT  = {1'b0, 6'd5},
    EXC_CAUSE_STORE_ACCESS_FAULT = {1'b0, 6'd7},
    EXC_CAUSE_ECALL_UMODE        = {1'b0, 6'd8},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 6'd11},
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 6'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 6'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 6'd11},
    EXC_CAUSE_IRQ_FAST_0         = {3'b101, 4'd0},
    EXC_CAUSE_IRQ_FAST_15        = {3'b101, 4'd15},
    EXC_CAUSE_IRQ_NM             = {1'b1, 6'd32}
  } exc_cause_e;

  // controller FSM, FLUSH is also seen by exc_detect
  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_state_e;

  // instruction sitting in ID
  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [15:0]     instr_c;
    logic            is_compressed;
    logic            fetch_err;
    logic            fetch_err_plus2;
    logic [XLEN-1:0] pc;
  } instr_info_t;

  // raw decoder flags, not qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebreak;
    logic csr_flush;
  } dec_flags_t;

  // interrupt lines already masked by mie
  typedef struct packed {
    logic                     irq_software;
    logic                     irq_timer;
    logic                     irq_external;
    logic [NUM_FAST_IRQS-1:0] irq_fast;
  } irqs_t;

  typedef struct packed {
    logic            req;
    exc_cause_e      cause;
    logic [XLEN-1:0] mtval;
    logic            mret;
    logic            wfi;
    logic            flush_only;
    logic            pc_change;
  } exc_req_t;

  typedef struct packed {
    logic       take;
    exc_cause_e cause;
    logic       nmi;
  } irq_req_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_ctrl_t;

  typedef struct packed {
    logic            save_if;
    logic            save_id;
    logic            restore_mret;
    logic            save_cause;
    exc_cause_e      exc_cause;
    logic [XLEN-1:0] mtval;
  } csr_ctrl_t;

endpackage

// File: src/ctrl_fsm.sv
//////////////////////////////
// controller FSM
// pc select, csr strobes, sleep and IF-ID control
//////////////////////////////
module ctrl_fsm import core_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        stall_id_i,
  input  logic        instr_valid_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        irq_nm_i,
  input  logic        irq_pending_i,
  input  exc_req_t    exc_i,
  input  irq_req_t    irq_i,
  output pc_ctrl_t    pc_o,
  output csr_ctrl_t   csr_o,
  output logic        instr_req_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,
  output logic        ctrl_busy_o,
  output logic        controller_run_o,
  output logic        nmi_mode_o,
  output ctrl_state_e state_o
);

  ctrl_state_e state_q, state_d;
  logic        nmi_mode_q, nmi_mode_d;
  logic        halt_if;
  logic        retain_id;
  logic        flush_id;
  logic        special_req;

  // anything that has to leave DECODE through FLUSH
  assign special_req = exc_i.pc_change | exc_i.flush_only;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_d          = state_q;
    nmi_mode_d       = nmi_mode_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    halt_if          = 1'b0;
    retain_id        = 1'b0;
    flush_id         = 1'b0;
    // mux values only matter together with pc_set
    pc_o.pc_set      = 1'b0;
    pc_o.pc_mux      = PC_BOOT;
    pc_o.exc_pc_mux  = EXC_PC_IRQ;
    csr_o            = '0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        pc_o.pc_set = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        // boot address into the fetch pc
        pc_o.pc_set = 1'b1;
        state_d     = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on anything pending, even with mie low
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait out the IF miss, ready is just ~stall here
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        // no ID content yet, so the irq goes straight in
        if (irq_i.take) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        pc_o.pc_mux      = PC_JUMP;

        // keep the instruction in ID so FLUSH can still see it
        if (special_req) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end

        if (branch_set_i || jump_set_i) begin
          pc_o.pc_set = 1'b1;
        end

        // hold off IF until ID drains before entering the handler
        if (irq_i.take && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end

        if (!stall_id_i && !special_req && !instr_valid_i && irq_i.take) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_o.pc_mux     = PC_EXC;
        pc_o.exc_pc_mux = EXC_PC_IRQ;
        if (irq_i.take) begin
          pc_o.pc_set     = 1'b1;
          csr_o.save_if   = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.exc_cause = irq_i.cause;
          if (irq_i.nmi) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (exc_i.req) begin
          // mepc gets the pc of the faulting instruction in ID
          pc_o.pc_set      = 1'b1;
          pc_o.pc_mux      = PC_EXC;
          pc_o.exc_pc_mux  = EXC_PC_EXC;
          csr_o.save_id    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.exc_cause  = exc_i.cause;
          csr_o.mtval      = exc_i.mtval;
        end else if (exc_i.mret) begin
          pc_o.pc_set        = 1'b1;
          pc_o.pc_mux        = PC_ERET;
          csr_o.restore_mret = 1'b1;
          // leaving the nmi handler
          nmi_mode_d         = 1'b0;
        end else if (exc_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
        // csr flush needs nothing beyond the flush itself
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // IF-ID handshake
  //////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // a stalled or retained instruction stays valid unless flushed
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;
  assign nmi_mode_o          = nmi_mode_q;
  assign state_o             = state_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  // state register holds a known code once out of reset
  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q));

  // a new instruction must not slip into ID behind one that is being flushed
  a_no_ready_into_flush : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_d == FLUSH) |-> !id_in_ready_o);

endmodule

// File: src/exc_detect.sv
//////////////////////////////
// exception detection
// qualifies decoder flags, registers requests,
// ranks sources and forms cause and mtval
//////////////////////////////
module exc_detect import core_ctrl_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  instr_info_t     instr_i,
  input  dec_flags_t      dec_i,
  input  priv_lvl_e       priv_i,
  input  logic            mstatus_tw_i,
  input  logic            load_err_i,
  input  logic            store_err_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  input  ctrl_state_e     state_i,
  output exc_req_t        exc_o
);

  // one flag per ranked source, msb has the highest rank
  typedef struct packed {
    logic fetch;
    logic illegal;
    logic ecall;
    logic ebrk;
    logic store;
    logic load;
  } prio_t;

  logic       illegal_insn;
  logic       ecall_insn;
  logic       mret_insn;
  logic       wfi_insn;
  logic       ebrk_insn;
  logic       csr_flush;
  logic       fetch_err;
  logic       illegal_umode;
  logic       illegal_d, illegal_q;
  logic       exc_req_d, exc_req_q;
  logic       load_err_q, store_err_q;
  prio_t      prio;
  exc_cause_e cause;
  logic [XLEN-1:0] mtval;

  //////////////////////////////
  // flag qualification
  //////////////////////////////

  // decoder looks at the word regardless of valid
  assign illegal_insn = dec_i.illegal   & instr_i.valid;
  assign ecall_insn   = dec_i.ecall     & instr_i.valid;
  assign mret_insn    = dec_i.mret      & instr_i.valid;
  assign wfi_insn     = dec_i.wfi       & instr_i.valid;
  assign ebrk_insn    = dec_i.ebreak    & instr_i.valid;
  assign csr_flush    = dec_i.csr_flush & instr_i.valid;
  assign fetch_err    = instr_i.fetch_err & instr_i.valid;

  // mret needs M-mode, tw traps wfi out of U-mode
  assign illegal_umode = (priv_i != PRIV_LVL_M) & (mret_insn | (mstatus_tw_i & wfi_insn));

  // both cleared in FLUSH so a handled request does not fire again
  assign illegal_d = (illegal_insn | illegal_umode) & (state_i != FLUSH);
  assign exc_req_d = (ecall_insn | ebrk_insn | illegal_d | fetch_err) & (state_i != FLUSH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_i;
      store_err_q <= store_err_i;
    end
  end

  //////////////////////////////
  // ranking, cause and mtval
  //////////////////////////////

  // order from the privileged spec, fetch fault first
  always_comb begin
    prio  = '0;
    cause = EXC_CAUSE_INSN_ADDR_MISA;
    mtval = '0;
    if (fetch_err) begin
      prio.fetch = 1'b1;
      cause      = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // second half of a word that straddles the fault
      mtval      = instr_i.fetch_err_plus2 ? (instr_i.pc + 32'd2) : instr_i.pc;
    end else if (illegal_q) begin
      prio.illegal = 1'b1;
      cause        = EXC_CAUSE_ILLEGAL_INSN;
      mtval        = instr_i.is_compressed ? {16'b0, instr_i.instr_c} : instr_i.instr;
    end else if (ecall_insn) begin
      prio.ecall = 1'b1;
      cause      = (priv_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      prio.ebrk = 1'b1;
      cause     = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      prio.store = 1'b1;
      cause      = EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval      = lsu_addr_last_i;
    end else if (load_err_q) begin
      prio.load = 1'b1;
      cause     = EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval     = lsu_addr_last_i;
    end
  end

  assign exc_o.req        = exc_req_q | store_err_q | load_err_q;
  assign exc_o.cause      = cause;
  assign exc_o.mtval      = mtval;
  assign exc_o.mret       = mret_insn;
  assign exc_o.wfi        = wfi_insn;
  assign exc_o.flush_only = wfi_insn | csr_flush;
  // lsu errors come from a later stage and carry no ID valid
  assign exc_o.pc_change  = mret_insn | exc_req_d | load_err_i | store_err_i;

  // the instruction retained in ID must still show the source registered last cycle
  a_prio_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == FLUSH) && exc_o.req |-> $onehot(prio));

endmodule

// File: src/irq_arbiter.sv
//////////////////////////////
// interrupt arbiter
// take decision, winner and cause
//////////////////////////////
module irq_arbiter import core_ctrl_pkg::*; (
  input  irqs_t    irqs_i,
  input  logic     irq_nm_i,
  input  logic     irq_pending_i,
  input  logic     mstatus_mie_i,
  input  logic     nmi_mode_i,
  output irq_req_t irq_o
);

  logic [3:0] fast_id;
  exc_cause_e cause;

  // lowest fast id wins, so scan down and keep the last hit
  always_comb begin
    fast_id = 4'd0;
    for (int i = NUM_FAST_IRQS - 1; i >= 0; i--) begin
      if (irqs_i.irq_fast[i]) begin
        fast_id = i[3:0];
      end
    end
  end

  // nmi, fast, external, software, timer
  always_comb begin
    cause = EXC_CAUSE_INSN_ADDR_MISA;
    if (irq_nm_i) begin
      cause = EXC_CAUSE_IRQ_NM;
    end else if (|irqs_i.irq_fast) begin
      cause = exc_cause_e'({3'b101, fast_id});
    end else if (irqs_i.irq_external) begin
      cause = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      cause = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irqs_i.irq_timer) begin
      cause = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // nothing nests inside an nmi handler, not even another nmi
  assign irq_o.take  = ~nmi_mode_i & (irq_nm_i | (irq_pending_i & mstatus_mie_i));
  assign irq_o.cause = cause;
  assign irq_o.nmi   = irq_nm_i & ~nmi_mode_i;

endmodule

// File: tb.f
src/core_ctrl_pkg.sv
src/exc_detect.sv
src/irq_arbiter.sv
src/ctrl_fsm.sv
src/core_controller.sv
tests/tb_clock_gen.sv
tests/tb_core_controller.sv

// File: tests/tb_clock_gen.sv
//////////////////////////////
// testbench clock and reset
// 10 ns clock, reset low for 4 cycles
//////////////////////////////
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // release between edges so the first driven row sees a clean reset
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

// File: tests/tb_core_controller.sv
//////////////////////////////
// controller testbench
// table of stimulus and expected outputs, one row per check,
// lfsr payloads, watchdog and report
//////////////////////////////
module tb_core_controller import core_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // status bits {instr_req, id_in_ready, valid_clear, flush_id, busy, run, nmi_mode}
  localparam logic [6:0] ST_RST  = 7'b0110100;
  localparam logic [6:0] ST_BOOT = 7'b1110100;
  localparam logic [6:0] ST_DEC  = 7'b1110110;
  localparam logic [6:0] ST_RET  = 7'b1000110;
  localparam logic [6:0] ST_FLU  = 7'b1011100;
  localparam logic [6:0] ST_IRQ  = 7'b1010110;
  // first fetch holding IF for an interrupt
  localparam logic [6:0] ST_HALT = 7'b1010100;
  localparam logic [6:0] ST_SLP  = 7'b0011000;
  localparam logic [6:0] ST_WAKE = 7'b0011100;
  localparam int         MAX_ROWS = 96;

  // inputs of one row, payload words come from the lfsr
  typedef struct packed {
    logic       fen;
    logic       valid;
    logic       fetch_err;
    logic       plus2;
    logic       comp;
    dec_flags_t dec;
    logic       stall;
    logic       lerr;
    logic       serr;
    logic       branch;
    logic       jump;
    logic       pend;
    irqs_t      irqs;
    logic       nm;
    logic       mie;
    logic       tw;
    priv_lvl_e  priv;
  } stim_t;

  // strobes {save_if, save_id, restore_mret, save_cause}
  // mtval kind 0 zero, 1 pc, 2 pc+2, 3 word, 4 halfword, 5 lsu address
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [3:0]  sv;
    logic [6:0]  cause;
    logic [2:0]  mk;
    logic [6:0]  st;
  } exp_t;

  logic            clk, rst_n;
  logic            fetch_enable, stall_id, load_err, store_err;
  logic            branch_set, jump_set, irq_pending, irq_nm, mie, tw;
  instr_info_t     instr;
  dec_flags_t      dec;
  irqs_t           irqs;
  priv_lvl_e       priv;
  logic [XLEN-1:0] lsu_addr;
  pc_ctrl_t        pc_ctrl;
  csr_ctrl_t       csr_ctrl;
  logic            instr_req, id_in_ready, valid_clear, flush_id;
  logic            busy, run, nmi_mode;

  stim_t           stim_tab [MAX_ROWS];
  exp_t            exp_tab  [MAX_ROWS];
  int              test_tab [MAX_ROWS];
  int              cyc_tab  [MAX_ROWS];
  int              n_rows;
  logic            table_ready;
  int              errors;
  int              test_errors;
  int              tests_run;
  int              tests_failed;
  logic [31:0]     lfsr;
  logic [XLEN-1:0] pay_pc, pay_word, pay_lsu;
  logic [15:0]     pay_half;

  tb_clock_gen u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  core_controller dut0 (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .fetch_enable_i      (fetch_enable),
    .instr_i             (instr),
    .dec_i               (dec),
    .stall_id_i          (stall_id),
    .load_err_i          (load_err),
    .store_err_i         (store_err),
    .lsu_addr_last_i     (lsu_addr),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .irq_pending_i       (irq_pending),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .mstatus_mie_i       (mie),
    .mstatus_tw_i        (tw),
    .priv_i              (priv),
    .pc_o                (pc_ctrl),
    .csr_o               (csr_ctrl),
    .instr_req_o         (instr_req),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (valid_clear),
    .flush_id_o          (flush_id),
    .ctrl_busy_o         (busy),
    .controller_run_o    (run),
    .nmi_mode_o          (nmi_mode)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic b;
    b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], b};
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic exp_t ex(logic ps, pc_sel_e m, exc_pc_sel_e x, logic [3:0] sv,
                              logic [6:0] c, logic [2:0] mk, logic [6:0] st);
    exp_t e;
    e.pc_set     = ps;
    e.pc_mux     = m;
    e.exc_pc_mux = x;
    e.sv         = sv;
    e.cause      = c;
    e.mk         = mk;
    e.st         = st;
    return e;
  endfunction

  function automatic exp_t quiet(logic [6:0] st);
    return ex(1'b0, PC_BOOT, EXC_PC_EXC, 4'b0000, 7'h00, 3'd0, st);
  endfunction

  function automatic string test_name(int t);
    case (t)
      1:       return "boot";
      2:       return "exception causes";
      3:       return "interrupts";
      4:       return "illegal mret and wfi";
      5:       return "wfi sleep";
      default: return "back-pressure";
    endcase
  endfunction

  // expected mtval from the trap rules
  function automatic logic [XLEN-1:0] mtval_of(logic [2:0] mk);
    case (mk)
      3'd1:    return pay_pc;
      3'd2:    return pay_pc + 32'd2;
      3'd3:    return pay_word;
      3'd4:    return {16'h0000, pay_half};
      3'd5:    return pay_lsu;
      default: return '0;
    endcase
  endfunction

  task automatic add(int t, int c, stim_t s, exp_t e);
    stim_tab[n_rows] = s;
    exp_tab[n_rows]  = e;
    test_tab[n_rows] = t;
    cyc_tab[n_rows]  = c;
    n_rows++;
  endtask

  // detect cycle in DECODE, trap in FLUSH, then back to idle
  task automatic exc_rows(int t, stim_t s, stim_t idle, logic [6:0] c, logic [2:0] mk);
    stim_t f;
    f      = s;
    f.lerr = 1'b0;
    f.serr = 1'b0;
    add(t, 1, s, quiet(ST_RET));
    add(t, 1, f, ex(1'b1, PC_EXC, EXC_PC_EXC, 4'b0101, c, mk, ST_FLU));
    add(t, 1, idle, quiet(ST_DEC));
  endtask

  task automatic irq_rows(int t, stim_t s, stim_t idle, logic [6:0] c, logic [6:0] st_after);
    add(t, 1, s, quiet(ST_IRQ));
    add(t, 1, s, ex(1'b1, PC_EXC, EXC_PC_IRQ, 4'b1001, c, 3'd0, ST_BOOT));
    add(t, 1, idle, quiet(st_after));
  endtask

  task automatic drive(stim_t s);
    fetch_enable        <= s.fen;
    instr.valid         <= s.valid;
    instr.instr         <= pay_word;
    instr.instr_c       <= pay_half;
    instr.is_compressed <= s.comp;
    instr.fetch_err     <= s.fetch_err;
    instr.fetch_err_plus2 <= s.plus2;
    instr.pc            <= pay_pc;
    dec                 <= s.dec;
    stall_id            <= s.stall;
    load_err            <= s.lerr;
    store_err           <= s.serr;
    lsu_addr            <= pay_lsu;
    branch_set          <= s.branch;
    jump_set            <= s.jump;
    irq_pending         <= s.pend;
    irqs                <= s.irqs;
    irq_nm              <= s.nm;
    mie                 <= s.mie;
    tw                  <= s.tw;
    priv                <= s.priv;
  endtask

  task automatic cmp(int r, string name, logic [31:0] e, logic [31:0] g);
    if (e !== g) begin
      $display("Mismatch row %0d %s expected %h got %h", r, name, e, g);
      test_errors++;
    end
  endtask

  task automatic check_row(int r);
    exp_t e;
    e = exp_tab[r];
    cmp(r, "pc_set", 32'(e.pc_set), 32'(pc_ctrl.pc_set));
    if (e.pc_set) begin
      cmp(r, "pc_mux", 32'(e.pc_mux), 32'(pc_ctrl.pc_mux));
      if (e.pc_mux == PC_EXC) begin
        cmp(r, "exc_pc_mux", 32'(e.exc_pc_mux), 32'(pc_ctrl.exc_pc_mux));
      end
    end
    cmp(r, "csr strobes", 32'(e.sv), 32'({csr_ctrl.save_if, csr_ctrl.save_id,
                                         csr_ctrl.restore_mret, csr_ctrl.save_cause}));
    cmp(r, "exc_cause", 32'(e.cause), 32'(csr_ctrl.exc_cause));
    cmp(r, "mtval", mtval_of(e.mk), csr_ctrl.mtval);
    cmp(r, "instr_req_o", 32'(e.st[6]), 32'(instr_req));
    cmp(r, "id_in_ready_o", 32'(e.st[5]), 32'(id_in_ready));
    cmp(r, "instr_valid_clear_o", 32'(e.st[4]), 32'(valid_clear));
    cmp(r, "flush_id_o", 32'(e.st[3]), 32'(flush_id));
    cmp(r, "ctrl_busy_o", 32'(e.st[2]), 32'(busy));
    cmp(r, "controller_run_o", 32'(e.st[1]), 32'(run));
    cmp(r, "nmi_mode_o", 32'(e.st[0]), 32'(nmi_mode));
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic build_table();
    stim_t b;
    stim_t s;
    b      = '0;
    b.fen  = 1'b1;
    b.mie  = 1'b1;
    b.priv = PRIV_LVL_M;

    // boot, then a branch and a jump in DECODE
    s = b;
    s.fen = 1'b0;
    add(1, 2, s, ex(1'b1, PC_BOOT, EXC_PC_EXC, 4'b0000, 7'h00, 3'd0, ST_RST));
    add(1, 1, b, ex(1'b1, PC_BOOT, EXC_PC_EXC, 4'b0000, 7'h00, 3'd0, ST_RST));
    add(1, 1, b, ex(1'b1, PC_BOOT, EXC_PC_EXC, 4'b0000, 7'h00, 3'd0, ST_BOOT));
    add(1, 1, b, quiet(ST_BOOT));
    add(1, 1, b, quiet(ST_DEC));
    s = b;
    s.branch = 1'b1;
    add(1, 1, s, ex(1'b1, PC_JUMP, EXC_PC_EXC, 4'b0000, 7'h00, 3'd0, ST_DEC));
    s = b;
    s.jump = 1'b1;
    add(1, 1, s, ex(1'b1, PC_JUMP, EXC_PC_EXC, 4'b0000, 7'h00, 3'd0, ST_DEC));
    add(1, 1, b, quiet(ST_DEC));

    // one source per row, then all at once
    s = b;
    s.valid = 1'b1;
    s.fetch_err = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_INSTR_ACCESS_FAULT, 3'd1);
    s.plus2 = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_INSTR_ACCESS_FAULT, 3'd2);
    s = b;
    s.valid = 1'b1;
    s.dec.illegal = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_ILLEGAL_INSN, 3'd3);
    s.comp = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_ILLEGAL_INSN, 3'd4);
    s = b;
    s.valid = 1'b1;
    s.dec.ecall = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_ECALL_MMODE, 3'd0);
    s.priv = PRIV_LVL_U;
    exc_rows(2, s, b, EXC_CAUSE_ECALL_UMODE, 3'd0);
    s = b;
    s.valid = 1'b1;
    s.dec.ebreak = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_BREAKPOINT, 3'd0);
    s = b;
    s.serr = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_STORE_ACCESS_FAULT, 3'd5);
    s = b;
    s.lerr = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_LOAD_ACCESS_FAULT, 3'd5);
    s = b;
    s.valid = 1'b1;
    s.fetch_err = 1'b1;
    s.dec.illegal = 1'b1;
    s.dec.ecall = 1'b1;
    s.serr = 1'b1;
    exc_rows(2, s, b, EXC_CAUSE_INSTR_ACCESS_FAULT, 3'd1);

    // fast 5 beats fast 9 and the three standard lines
    s = b;
    s.pend = 1'b1;
    s.irqs = '{irq_software: 1'b1, irq_timer: 1'b1, irq_external: 1'b1,
               irq_fast: 16'h0220};
    irq_rows(3, s, b, {3'b101, 4'd5}, ST_DEC);
    s.irqs.irq_fast = 16'h0000;
    irq_rows(3, s, b, EXC_CAUSE_IRQ_EXTERNAL_M, ST_DEC);
    s.irqs.irq_external = 1'b0;
    irq_rows(3, s, b, EXC_CAUSE_IRQ_SOFTWARE_M, ST_DEC);
    s.irqs.irq_software = 1'b0;
    irq_rows(3, s, b, EXC_CAUSE_IRQ_TIMER_M, ST_DEC);
    // mie low holds everything off
    s.irqs.irq_external = 1'b1;
    s.mie = 1'b0;
    add(3, 3, s, quiet(ST_DEC));
    // nmi gets through with mie low and enters nmi mode
    s.nm = 1'b1;
    irq_rows(3, s, b, EXC_CAUSE_IRQ_NM, ST_DEC | 7'b0000001);
    s.mie = 1'b1;
    add(3, 3, s, quiet(ST_DEC | 7'b0000001));
    s = b;
    s.valid = 1'b1;
    s.dec.mret = 1'b1;
    add(3, 1, s, quiet(ST_RET | 7'b0000001));
    add(3, 1, s, ex(1'b1, PC_ERET, EXC_PC_EXC, 4'b0010, 7'h00, 3'd0, ST_FLU | 7'b0000001));
    add(3, 1, b, quiet(ST_DEC));

    // mret and trapped wfi out of U-mode
    s = b;
    s.valid = 1'b1;
    s.priv = PRIV_LVL_U;
    s.dec.mret = 1'b1;
    exc_rows(4, s, b, EXC_CAUSE_ILLEGAL_INSN, 3'd3);
    s.dec.mret = 1'b0;
    s.dec.wfi = 1'b1;
    s.tw = 1'b1;
    exc_rows(4, s, b, EXC_CAUSE_ILLEGAL_INSN, 3'd3);

    // wfi, sleep, wake on a pending external line
    s = b;
    s.valid = 1'b1;
    s.dec.wfi = 1'b1;
    add(5, 1, s, quiet(ST_RET));
    add(5, 1, s, quiet(ST_FLU));
    add(5, 1, b, quiet(ST_SLP));
    add(5, 4, b, quiet(ST_SLP));
    s = b;
    s.pend = 1'b1;
    s.irqs.irq_external = 1'b1;
    add(5, 1, s, quiet(ST_WAKE));
    add(5, 1, s, quiet(ST_HALT));
    add(5, 1, s, ex(1'b1, PC_EXC, EXC_PC_IRQ, 4'b1001, EXC_CAUSE_IRQ_EXTERNAL_M, 3'd0,
                    ST_BOOT));
    add(5, 1, b, quiet(ST_DEC));

    // stall holds the instruction and defers the interrupt, checked every cycle
    s.stall = 1'b1;
    s.valid = 1'b1;
    repeat (3) begin
      add(6, 1, s, quiet(ST_RET));
    end
    s.stall = 1'b0;
    s.valid = 1'b0;
    irq_rows(6, s, b, EXC_CAUSE_IRQ_EXTERNAL_M, ST_DEC);
  endtask

  //////////////////////////////
  // run and report
  //////////////////////////////

  initial begin
    table_ready  = 1'b0;
    n_rows       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr         = 32'd94112;
    pay_pc       = '0;
    pay_word     = '0;
    pay_half     = '0;
    pay_lsu      = '0;
    drive('0);
    build_table();
    table_ready = 1'b1;
    @(posedge rst_n);
    for (int r = 0; r < n_rows; r++) begin
      // fresh payload at the start of each test
      if (r == 0 || test_tab[r] != test_tab[r-1]) begin
        pay_pc   = rand_bits(31) << 1;
        pay_word = rand_bits(32);
        pay_half = 16'(rand_bits(16));
        pay_lsu  = rand_bits(32);
      end
      @(posedge clk);
      drive(stim_tab[r]);
      repeat (cyc_tab[r] - 1) @(posedge clk);
      @(negedge clk);
      check_row(r);
      if (r == n_rows - 1 || test_tab[r+1] != test_tab[r]) begin
        tests_run++;
        if (test_errors > 0) begin
          tests_failed++;
        end
        $display("test %0d %s: %s", test_tab[r], test_name(test_tab[r]),
                 (test_errors == 0) ? "ok" : "failed");
        errors      = errors + test_errors;
        test_errors = 0;
      end
    end
    $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // generous bound of 20 cycles per table row
  initial begin
    wait (table_ready);
    repeat (n_rows * 20) @(posedge clk);
    $display("watchdog expired before the table finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule
